/* src/cp0_pkg.sv */
`default_nettype none

package cp0_pkg;

    typedef logic [7:0]  reg_addr_t; // {register number, select}
    typedef logic [31:0] word_t;
    typedef logic [4:0]  exc_code_t;
    typedef logic [3:0]  tlb_idx_t;
    typedef logic [7:0]  asid_t;
    typedef logic [18:0] vpn2_t;
    typedef logic [23:0] pfn_t;

    localparam reg_addr_t REG_INDEX    = {5'd0, 3'd0};
    localparam reg_addr_t REG_RANDOM   = {5'd1, 3'd0};
    localparam reg_addr_t REG_ENTRYLO0 = {5'd2, 3'd0};
    localparam reg_addr_t REG_ENTRYLO1 = {5'd3, 3'd0};
    localparam reg_addr_t REG_CONTEXT  = {5'd4, 3'd0};
    localparam reg_addr_t REG_WIRED    = {5'd6, 3'd0};
    localparam reg_addr_t REG_BADVADDR = {5'd8, 3'd0};
    localparam reg_addr_t REG_COUNT    = {5'd9, 3'd0};
    localparam reg_addr_t REG_ENTRYHI  = {5'd10, 3'd0};
    localparam reg_addr_t REG_COMPARE  = {5'd11, 3'd0};
    localparam reg_addr_t REG_STATUS   = {5'd12, 3'd0};
    localparam reg_addr_t REG_CAUSE    = {5'd13, 3'd0};
    localparam reg_addr_t REG_EPC      = {5'd14, 3'd0};
    localparam reg_addr_t REG_PRID     = {5'd15, 3'd0};
    localparam reg_addr_t REG_EBASE    = {5'd15, 3'd1};
    localparam reg_addr_t REG_CONFIG   = {5'd16, 3'd0};
    localparam reg_addr_t REG_CONFIG1  = {5'd16, 3'd1};

    localparam int       TLB_ENTRIES = 16;
    localparam tlb_idx_t TLB_LAST    = tlb_idx_t'(TLB_ENTRIES - 1);

    localparam word_t       STATUS_RESET   = 32'h1040_0004; // CU0, BEV, ERL
    localparam word_t       EBASE_RESET    = 32'h8000_0000;
    localparam word_t       PRID_VALUE     = 32'h0001_8000; // 4Kc style ID
    localparam word_t       BOOT_VECTOR    = 32'hBFC0_0380;
    localparam logic [15:0] GEN_VEC_OFFSET = 16'h0180;

    // Writable fields, other bits keep their value
    localparam word_t STATUS_WMASK  = 32'h1040_FF17; // CU0 BEV IM UM ERL EXL IE
    localparam word_t CAUSE_WMASK   = 32'h0080_0300; // IV and software IP
    localparam word_t ENTRYHI_WMASK = 32'hFFFF_E0FF;
    localparam word_t ENTRYLO_WMASK = 32'h3FFF_FFFF;
    localparam word_t EBASE_WMASK   = 32'h3FFF_F000;
    localparam word_t CONTEXT_WMASK = 32'hFF80_0000; // PTEBase only

    localparam exc_code_t EXC_INT  = 5'd0;
    localparam exc_code_t EXC_TLBL = 5'd2;
    localparam exc_code_t EXC_TLBS = 5'd3;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_SYS  = 5'd8;
    localparam exc_code_t EXC_BP   = 5'd9;
    localparam exc_code_t EXC_RI   = 5'd10;
    localparam exc_code_t EXC_OV   = 5'd12;

endpackage

`default_nettype wire

/* src/cp0_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface exc_if
    import cp0_pkg::*;
();
    logic       valid;
    exc_code_t  code;
    word_t      epc;
    logic       bd;
    word_t      bad_vaddr;
    logic       badv_we;
    logic [7:0] int_pending_src; // Software and timer IP after IM
    logic [7:0] int_mask;
    logic       allow_int;
    logic       bev;
    word_t      ebase;

    modport producer (
        output valid, code, epc, bd, bad_vaddr, badv_we,
        input  int_pending_src, int_mask, allow_int, bev, ebase
    );
    modport consumer (
        input  valid, code, epc, bd, bad_vaddr, badv_we,
        output int_pending_src, int_mask, allow_int, bev, ebase
    );
endinterface

interface tlb_if
    import cp0_pkg::*;
();
    vpn2_t      vpn2;
    asid_t      asid;
    pfn_t       pfn0;
    pfn_t       pfn1;
    logic [4:0] flags0; // C, D, V
    logic [4:0] flags1;
    logic       g;
    tlb_idx_t   wr_idx;
    logic       wr_en;
    vpn2_t      probe_vpn2;
    asid_t      probe_asid;
    logic       probe_hit;
    tlb_idx_t   probe_idx;

    modport master (
        output vpn2, asid, pfn0, pfn1, flags0, flags1, g, wr_idx, wr_en,
        output probe_vpn2, probe_asid,
        input  probe_hit, probe_idx
    );
    modport slave (
        input  vpn2, asid, pfn0, pfn1, flags0, flags1, g, wr_idx, wr_en,
        input  probe_vpn2, probe_asid,
        output probe_hit, probe_idx
    );
endinterface

`default_nettype wire

/* src/exc_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module exc_arbiter
    import cp0_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire [5:0]      hw_int_i,
    input  wire            exc_req_i,
    input  wire exc_code_t exc_code_i,
    input  wire word_t     exc_epc_i,
    input  wire            exc_bd_i,
    input  wire word_t     exc_bad_vaddr_i,
    output logic           exc_taken_o,
    output word_t          exc_vector_o,
    exc_if.producer        exc
);

    logic [7:0] ip_masked;
    logic       int_pending;
    word_t      vector;

    assign ip_masked   = exc.int_pending_src | {exc.int_mask[7:2] & hw_int_i, 2'b00};
    assign int_pending = exc.allow_int && (ip_masked != 8'b0);

    // Interrupt beats a synchronous request, the core replays the instruction
    assign exc.valid     = int_pending | exc_req_i;
    assign exc.code      = int_pending ? EXC_INT : exc_code_i;
    assign exc.epc       = exc_epc_i;
    assign exc.bd        = exc_bd_i;
    assign exc.bad_vaddr = exc_bad_vaddr_i;
    assign exc.badv_we   = !int_pending && (exc_code_i inside {EXC_TLBL, EXC_TLBS, EXC_ADEL});

    assign vector = exc.bev ? BOOT_VECTOR : exc.ebase + 32'(GEN_VEC_OFFSET);

    always_ff @(posedge clk) begin
        if (!rst_n)
            exc_taken_o <= 1'b0;
        else
            exc_taken_o <= exc.valid;
    end

    always_ff @(posedge clk) begin
        if (exc.valid)
            exc_vector_o <= vector; // Held until next entry
    end

endmodule

`default_nettype wire

/* src/tlb_array.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb_array
    import cp0_pkg::*;
(
    input  wire  clk,
    input  wire  rst_n,
    tlb_if.slave tlb
);

    vpn2_t                  vpn2_mem [TLB_ENTRIES];
    asid_t                  asid_mem [TLB_ENTRIES];
    logic                   g_mem    [TLB_ENTRIES];
    logic [28:0]            lo0_mem  [TLB_ENTRIES]; // {PFN, C, D, V} for even page
    logic [28:0]            lo1_mem  [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] live_q;
    logic [TLB_ENTRIES-1:0] match;

    always_ff @(posedge clk) begin
        if (!rst_n)
            live_q <= '0;
        else if (tlb.wr_en)
            live_q[tlb.wr_idx] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (tlb.wr_en) begin
            vpn2_mem[tlb.wr_idx] <= tlb.vpn2;
            asid_mem[tlb.wr_idx] <= tlb.asid;
            g_mem[tlb.wr_idx]    <= tlb.g;
            lo0_mem[tlb.wr_idx]  <= {tlb.pfn0, tlb.flags0};
            lo1_mem[tlb.wr_idx]  <= {tlb.pfn1, tlb.flags1};
        end
    end

    // Lookup side of lo0/lo1 lives in the fetch and load MMU
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = live_q[i] && (vpn2_mem[i] == tlb.probe_vpn2)
                       && (g_mem[i] || asid_mem[i] == tlb.probe_asid);
        end
    end

    always_comb begin
        tlb.probe_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i])
                tlb.probe_idx = tlb_idx_t'(i); // Lowest index wins
        end
    end

    assign tlb.probe_hit = |match;

endmodule

`default_nettype wire

/* src/cp0_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module cp0_regfile
    import cp0_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire reg_addr_t rd_addr_i,
    output word_t          rd_data_o,
    input  wire            we_i,
    input  wire reg_addr_t wr_addr_i,
    input  wire word_t     wr_data_i,
    input  wire [5:0]      hw_int_i,
    input  wire            eret_i,
    input  wire            tlbwi_i,
    input  wire            tlbwr_i,
    input  wire            tlbp_i,
    output logic           timer_int_o,
    output logic           exl_o,
    output logic           user_mode_o,
    exc_if.consumer        exc,
    tlb_if.master          tlb
);

    word_t      status_q, cause_q, count_q, compare_q, epc_q, badvaddr_q;
    word_t      ebase_q, entryhi_q, entrylo0_q, entrylo1_q, context_q;
    logic       index_p;
    tlb_idx_t   index_q, random_q, wired_q;
    logic [2:0] k0_q;
    logic [5:0] hw_ip;

    assign hw_ip       = {hw_int_i[5] | timer_int_o, hw_int_i[4:0]}; // Timer shares IP7
    assign exl_o       = status_q[1];
    assign user_mode_o = status_q[4:1] == 4'b1000;

    assign exc.int_mask        = status_q[15:8];
    assign exc.int_pending_src = status_q[15:8] & {timer_int_o, 5'b0, cause_q[9:8]};
    assign exc.allow_int       = status_q[2:0] == 3'b001; // IE set, EXL and ERL clear
    assign exc.bev             = status_q[22];
    assign exc.ebase           = ebase_q;

    assign tlb.vpn2       = entryhi_q[31:13];
    assign tlb.asid       = entryhi_q[7:0];
    assign tlb.pfn0       = entrylo0_q[29:6];
    assign tlb.pfn1       = entrylo1_q[29:6];
    assign tlb.flags0     = entrylo0_q[5:1];
    assign tlb.flags1     = entrylo1_q[5:1];
    assign tlb.g          = entrylo0_q[0] & entrylo1_q[0];
    assign tlb.wr_idx     = tlbwr_i ? random_q : index_q;
    assign tlb.wr_en      = tlbwi_i | tlbwr_i;
    assign tlb.probe_vpn2 = entryhi_q[31:13];
    assign tlb.probe_asid = entryhi_q[7:0];

    always_comb begin
        case (rd_addr_i)
            REG_INDEX:    rd_data_o = {index_p, 27'b0, index_q};
            REG_RANDOM:   rd_data_o = {28'b0, random_q};
            REG_ENTRYLO0: rd_data_o = entrylo0_q;
            REG_ENTRYLO1: rd_data_o = entrylo1_q;
            REG_CONTEXT:  rd_data_o = {context_q[31:4], 4'b0};
            REG_WIRED:    rd_data_o = {28'b0, wired_q};
            REG_BADVADDR: rd_data_o = badvaddr_q;
            REG_COUNT:    rd_data_o = count_q;
            REG_ENTRYHI:  rd_data_o = entryhi_q;
            REG_COMPARE:  rd_data_o = compare_q;
            REG_STATUS:   rd_data_o = status_q;
            REG_CAUSE:    rd_data_o = {cause_q[31:16], hw_ip, cause_q[9:0]};
            REG_EPC:      rd_data_o = epc_q;
            REG_PRID:     rd_data_o = PRID_VALUE;
            REG_EBASE:    rd_data_o = ebase_q;
            REG_CONFIG:   rd_data_o = {1'b1, 21'b0, 3'd1, 4'b0, k0_q}; // MT=TLB, AR=0 is rel 1
            REG_CONFIG1:  rd_data_o = {1'b0, 6'(TLB_ENTRIES - 1), 25'b0};
            default:      rd_data_o = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_q    <= STATUS_RESET;
            cause_q     <= '0;
            count_q     <= '0;
            compare_q   <= '0;
            ebase_q     <= EBASE_RESET;
            random_q    <= TLB_LAST;
            wired_q     <= '0;
            k0_q        <= 3'd3;
            timer_int_o <= 1'b0;
        end else begin
            count_q <= count_q + 32'd1;
            if (compare_q != '0 && compare_q == count_q)
                timer_int_o <= 1'b1;
            if (we_i) begin
                case (wr_addr_i)
                    REG_INDEX:    index_q <= wr_data_i[3:0]; // P bit is read only
                    REG_ENTRYLO0: entrylo0_q <= wr_data_i & ENTRYLO_WMASK;
                    REG_ENTRYLO1: entrylo1_q <= wr_data_i & ENTRYLO_WMASK;
                    REG_CONTEXT:  context_q <= (context_q & ~CONTEXT_WMASK)
                                               | (wr_data_i & CONTEXT_WMASK);
                    REG_WIRED: begin
                        wired_q  <= wr_data_i[3:0];
                        random_q <= TLB_LAST;
                    end
                    REG_COUNT:    count_q <= wr_data_i;
                    REG_ENTRYHI:  entryhi_q <= wr_data_i & ENTRYHI_WMASK;
                    REG_COMPARE: begin
                        compare_q   <= wr_data_i;
                        timer_int_o <= 1'b0; // Acknowledge
                    end
                    REG_STATUS:   status_q <= wr_data_i & STATUS_WMASK;
                    REG_CAUSE:    cause_q <= (cause_q & ~CAUSE_WMASK) | (wr_data_i & CAUSE_WMASK);
                    REG_EPC:      epc_q <= wr_data_i;
                    REG_EBASE:    ebase_q <= (ebase_q & ~EBASE_WMASK) | (wr_data_i & EBASE_WMASK);
                    REG_CONFIG:   k0_q <= wr_data_i[2:0];
                    default: ;
                endcase
            end
            if (tlbwr_i)
                random_q <= (random_q == wired_q) ? TLB_LAST : random_q - 4'd1;
            if (tlbp_i) begin
                index_p <= ~tlb.probe_hit;
                index_q <= tlb.probe_idx;
            end
            if (eret_i)
                status_q[1] <= 1'b0;
            // Entry wins over a same-cycle ERET
            if (exc.valid) begin
                if (!status_q[1]) begin
                    epc_q       <= exc.epc; // Nested entry keeps first EPC
                    cause_q[31] <= exc.bd;
                end
                cause_q[6:2] <= exc.code;
                status_q[1]  <= 1'b1;
                if (exc.badv_we) begin
                    badvaddr_q       <= exc.bad_vaddr;
                    context_q[22:4]  <= exc.bad_vaddr[31:13];
                    entryhi_q[31:13] <= exc.bad_vaddr[31:13];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/cp0_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cp0_top
    import cp0_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire reg_addr_t rd_addr_i,
    output word_t          rd_data_o,
    input  wire            we_i,
    input  wire reg_addr_t wr_addr_i,
    input  wire word_t     wr_data_i,
    input  wire [5:0]      hw_int_i,
    input  wire            exc_req_i,
    input  wire exc_code_t exc_code_i,
    input  wire word_t     exc_epc_i,
    input  wire            exc_bd_i,
    input  wire word_t     exc_bad_vaddr_i,
    input  wire            eret_i,
    input  wire            tlbwi_i,
    input  wire            tlbwr_i,
    input  wire            tlbp_i,
    output logic           timer_int_o,
    output logic           exc_taken_o,
    output word_t          exc_vector_o,
    output logic           exl_o,
    output logic           user_mode_o
);

    exc_if exc_bus ();
    tlb_if tlb_bus ();

    exc_arbiter u_arbiter (
        .clk             (clk),
        .rst_n           (rst_n),
        .hw_int_i        (hw_int_i),
        .exc_req_i       (exc_req_i),
        .exc_code_i      (exc_code_i),
        .exc_epc_i       (exc_epc_i),
        .exc_bd_i        (exc_bd_i),
        .exc_bad_vaddr_i (exc_bad_vaddr_i),
        .exc_taken_o     (exc_taken_o),
        .exc_vector_o    (exc_vector_o),
        .exc             (exc_bus.producer)
    );

    cp0_regfile u_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_addr_i   (rd_addr_i),
        .rd_data_o   (rd_data_o),
        .we_i        (we_i),
        .wr_addr_i   (wr_addr_i),
        .wr_data_i   (wr_data_i),
        .hw_int_i    (hw_int_i),
        .eret_i      (eret_i),
        .tlbwi_i     (tlbwi_i),
        .tlbwr_i     (tlbwr_i),
        .tlbp_i      (tlbp_i),
        .timer_int_o (timer_int_o),
        .exl_o       (exl_o),
        .user_mode_o (user_mode_o),
        .exc         (exc_bus.consumer),
        .tlb         (tlb_bus.master)
    );

    tlb_array u_tlb (
        .clk   (clk),
        .rst_n (rst_n),
        .tlb   (tlb_bus.slave)
    );

endmodule

`default_nettype wire

/* tests/cp0_props.sv */
`timescale 1ns/1ns
`default_nettype none

module cp0_props
    import cp0_pkg::*;
(
    input wire            clk,
    input wire            rst_n,
    input wire            we_i,
    input wire reg_addr_t wr_addr_i,
    input wire            timer_int_o,
    input wire            exc_taken_o,
    input wire            exl_o
);

    // EXL is set on the edge that registers the entry
    taken_sets_exl: assert property (
        @(posedge clk) disable iff (!rst_n)
        exc_taken_o |-> exl_o
    ) else $error("exl_o low while exc_taken_o is high");

    compare_write_acks_timer: assert property (
        @(posedge clk) disable iff (!rst_n)
        (we_i && wr_addr_i == REG_COMPARE) |=> !timer_int_o
    ) else $error("timer_int_o high in the cycle after a Compare write");

    no_entry_in_reset: assert property (
        @(posedge clk)
        !rst_n |=> !exc_taken_o
    ) else $error("exc_taken_o high during reset");

endmodule

`default_nettype wire

/* tests/tb_cp0.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cp0
    import cp0_pkg::*;
();

    localparam int MAX_CYCLES = 2000; // Whole sequence needs under 200

    logic       clk;
    logic       rst_n;
    reg_addr_t  rd_addr_i;
    reg_addr_t  wr_addr_i;
    word_t      rd_data_o;
    word_t      wr_data_i;
    word_t      exc_epc_i;
    word_t      exc_bad_vaddr_i;
    word_t      exc_vector_o;
    logic       we_i;
    logic [5:0] hw_int_i;
    logic       exc_req_i;
    exc_code_t  exc_code_i;
    logic       exc_bd_i;
    logic       eret_i;
    logic       tlbwi_i;
    logic       tlbwr_i;
    logic       tlbp_i;
    logic       timer_int_o;
    logic       exc_taken_o;
    logic       exl_o;
    logic       user_mode_o;

    logic [31:0] lfsr_q = 32'h61db_daf2;
    int          cycle_cnt = 0;

    cp0_top UUT (.*);

    bind cp0_top cp0_props u_props (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES)
            fail_run("Run exceeded the cycle limit without finishing");
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32+x^22+x^2+x+1
    endfunction

    task automatic random_word(output word_t w);
        repeat (32) begin
            lfsr_q = lfsr_next(lfsr_q);
            w = {w[30:0], lfsr_q[0]};
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got == exp)
        else fail_run($sformatf("[ERROR] t=%0t %s expected 32'h%08h got 32'h%08h",
                                $time, name, exp, got));
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond)
        else fail_run(what);
    endtask

    task automatic read_reg(input reg_addr_t addr, output word_t data);
        @(negedge clk);
        rd_addr_i = addr;
        #10;
        data = rd_data_o;
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        @(negedge clk);
        we_i      = 1'b1;
        wr_addr_i = addr;
        wr_data_i = data;
        @(negedge clk);
        we_i = 1'b0;
    endtask

    task automatic pulse_tlb(input logic wi, input logic wr, input logic p);
        @(negedge clk);
        tlbwi_i = wi;
        tlbwr_i = wr;
        tlbp_i  = p;
        @(negedge clk);
        tlbwi_i = 1'b0;
        tlbwr_i = 1'b0;
        tlbp_i  = 1'b0;
    endtask

    task automatic pulse_eret();
        @(negedge clk);
        eret_i = 1'b1;
        @(negedge clk);
        eret_i = 1'b0;
    endtask

    task automatic check_masked(input reg_addr_t addr, input string name,
                                input word_t mask, input word_t fixed);
        word_t w;
        word_t got;
        random_word(w);
        write_reg(addr, w);
        read_reg(addr, got);
        check_word(name, got, fixed | (w & mask));
    endtask

    task automatic wait_rise(input bit use_timer, input int limit, input string what);
        int n;
        n = 0;
        while (!(use_timer ? timer_int_o : exc_taken_o)) begin
            if (n == limit)
                fail_run({what, " did not rise in time"});
            else begin
                n++;
                @(negedge clk);
            end
        end
    endtask

    initial begin
        word_t    w;
        word_t    got;
        word_t    ebase;
        word_t    vaddr;
        word_t    hi;
        tlb_idx_t exp_rnd;
        int       k;
        rst_n           = 1'b0;
        rd_addr_i       = REG_STATUS;
        wr_addr_i       = REG_STATUS;
        wr_data_i       = '0;
        we_i            = 1'b0;
        hw_int_i        = '0;
        exc_req_i       = 1'b0;
        exc_code_i      = EXC_INT;
        exc_epc_i       = '0;
        exc_bd_i        = 1'b0;
        exc_bad_vaddr_i = '0;
        eret_i          = 1'b0;
        tlbwi_i         = 1'b0;
        tlbwr_i         = 1'b0;
        tlbp_i          = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        read_reg(REG_STATUS, got);
        check_word("Status", got, STATUS_RESET);
        read_reg(REG_PRID, got);
        check_word("PRId", got, PRID_VALUE);
        read_reg(REG_CONFIG1, got);
        check_word("Config1.MMUSize", {26'b0, got[30:25]}, 32'd15);
        read_reg(REG_COUNT, w);
        read_reg(REG_COUNT, got);
        check_true(w != '0, "Count stayed at zero after reset");
        check_true(got > w, "Count did not increase between reads");

        check_masked(REG_STATUS, "Status", STATUS_WMASK, '0);
        write_reg(REG_STATUS, 32'h0000_0010); // UM only
        check_true(user_mode_o, "user_mode_o low with UM set and EXL, ERL clear");
        write_reg(REG_STATUS, 32'h0040_0004); // BEV and ERL, interrupts off
        check_true(!user_mode_o, "user_mode_o high with ERL set");
        check_masked(REG_CAUSE, "Cause", CAUSE_WMASK, '0);
        check_masked(REG_ENTRYHI, "EntryHi", ENTRYHI_WMASK, '0);
        check_masked(REG_ENTRYLO0, "EntryLo0", ENTRYLO_WMASK, '0);
        check_masked(REG_ENTRYLO1, "EntryLo1", ENTRYLO_WMASK, '0);
        check_masked(REG_EBASE, "EBase", EBASE_WMASK, EBASE_RESET & ~EBASE_WMASK);
        check_masked(REG_PRID, "PRId", '0, PRID_VALUE);

        write_reg(REG_COUNT, 32'd0);
        write_reg(REG_COMPARE, 32'd20);
        wait_rise(1'b1, 22, "timer_int_o");
        write_reg(REG_COMPARE, 32'd0);
        check_true(!timer_int_o, "timer_int_o still high after Compare write");

        write_reg(REG_STATUS, 32'h0040_0401); // BEV, IM2, IE
        random_word(w);
        @(negedge clk);
        exc_epc_i  = w;
        exc_req_i  = 1'b1;
        exc_code_i = EXC_SYS; // Loses to the interrupt
        hw_int_i   = 6'b000001;
        wait_rise(1'b0, 4, "exc_taken_o on hw_int_i[0]");
        hw_int_i  = '0;
        exc_req_i = 1'b0;
        check_true(exl_o, "exl_o low after interrupt entry");
        check_word("exc_vector_o", exc_vector_o, BOOT_VECTOR);
        read_reg(REG_CAUSE, got);
        check_word("Cause.ExcCode", {27'b0, got[6:2]}, {27'b0, EXC_INT});
        read_reg(REG_EPC, got);
        check_word("EPC", got, w);
        pulse_eret();
        check_true(!exl_o, "eret_i did not clear exl_o");

        write_reg(REG_STATUS, 32'h0000_0000); // BEV and IE clear
        ebase = 32'h8001_2000;
        write_reg(REG_EBASE, ebase);
        random_word(vaddr);
        random_word(w);
        @(negedge clk);
        exc_req_i       = 1'b1;
        exc_code_i      = EXC_TLBL;
        exc_bad_vaddr_i = vaddr;
        exc_epc_i       = w;
        wait_rise(1'b0, 4, "exc_taken_o on TLBL request");
        exc_req_i = 1'b0;
        check_word("exc_vector_o", exc_vector_o, ebase + 32'h0000_0180);
        read_reg(REG_BADVADDR, got);
        check_word("BadVAddr", got, vaddr);
        read_reg(REG_CAUSE, got);
        check_word("Cause.ExcCode", {27'b0, got[6:2]}, {27'b0, EXC_TLBL});
        read_reg(REG_EPC, got);
        check_word("EPC", got, w);
        pulse_eret();

        random_word(hi);
        write_reg(REG_ENTRYHI, hi);
        random_word(w);
        write_reg(REG_ENTRYLO0, w);
        random_word(w);
        write_reg(REG_ENTRYLO1, w);
        write_reg(REG_INDEX, 32'd5);
        pulse_tlb(1'b1, 1'b0, 1'b0);
        write_reg(REG_INDEX, 32'd0);
        pulse_tlb(1'b0, 1'b0, 1'b1);
        read_reg(REG_INDEX, got);
        check_word("Index", got, 32'd5);
        write_reg(REG_ENTRYHI, hi ^ 32'h0000_2000); // Lowest VPN2 bit
        pulse_tlb(1'b0, 1'b0, 1'b1);
        read_reg(REG_INDEX, got);
        check_true(got[31], "TLBP miss did not set Index bit 31");

        pulse_tlb(1'b0, 1'b1, 1'b0); // Moves Random off 15
        write_reg(REG_WIRED, 32'd3);
        exp_rnd = 4'd15;
        for (k = 0; k < 14; k++) begin
            read_reg(REG_RANDOM, got);
            check_word("Random", got, {28'b0, exp_rnd});
            pulse_tlb(1'b0, 1'b1, 1'b0);
            exp_rnd = (exp_rnd == 4'd3) ? 4'd15 : exp_rnd - 4'd1;
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
src/cp0_pkg.sv
src/cp0_if.sv
src/exc_arbiter.sv
src/tlb_array.sv
src/cp0_regfile.sv
src/cp0_top.sv
tests/cp0_props.sv
tests/tb_cp0.sv

/* Makefile */
TOP := tb_cp0

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f src/*.sv tests/*.sv
	verilator --binary --timing --assert -f files.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir
